// File: rtl/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int data_w = 32;
	localparam int num_regs = 16;
	localparam int imm_w = 19; // Immediate field of the itype view

	typedef logic [3:0] reg_idx_t;

	typedef enum logic [4:0] {
		add    = 5'd0,
		sub    = 5'd1,
		and_op = 5'd2,
		or_op  = 5'd3,
		shl    = 5'd4,
		shr    = 5'd5,
		mul    = 5'd6,
		ldi    = 5'd7,
		out    = 5'd8,
		halt   = 5'd9
	} opcode_t;

	// One instruction word, two ways of reading it
	typedef union packed {
		struct packed {
			opcode_t     opcode;
			reg_idx_t    ra; // Destination
			reg_idx_t    rb;
			reg_idx_t    rc;
			logic [14:0] unused;
		} rtype;
		struct packed {
			opcode_t          opcode;
			reg_idx_t         ra;
			reg_idx_t         rb; // Source for out
			logic [imm_w-1:0] imm;
		} itype;
	} instr_t;

	typedef enum logic [2:0] {
		src_gpr = 3'd0,
		src_pc  = 3'd1,
		src_mdr = 3'd2,
		src_z   = 3'd3,
		src_imm = 3'd4
	} bus_src_t;

	typedef struct packed {
		bus_src_t bus_src;
		reg_idx_t gpr_read;
		reg_idx_t gpr_write;
		logic     gpr_we;
		logic     pc_we;
		logic     pc_inc; // Z loads bus plus one instead of the ALU result
		logic     mar_we;
		logic     mdr_we; // Qualified by ack in the datapath
		logic     ir_we;
		logic     y_we;
		logic     z_we;
		logic     out_we;
		opcode_t  alu_op;
	} ctrl_t;

	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic [31:0] adr;
	} wb_req_t;

	typedef struct packed {
		logic        ack;
		logic [31:0] dat;
	} wb_rsp_t;

endpackage

`default_nettype wire

// File: rtl/alu.sv
`timescale 1ns/1ns
`default_nettype none

module alu (
	input  cpu_pkg::opcode_t           op,
	input  logic [cpu_pkg::data_w-1:0] a,
	input  logic [cpu_pkg::data_w-1:0] b,
	output logic [cpu_pkg::data_w-1:0] result
);
	import cpu_pkg::*;

	logic [4:0]        shamt;
	logic [data_w-1:0] product;

	assign shamt   = b[4:0];
	assign product = a * b; // Low half of the full product

	always_comb begin
		case (op)
			add:     result = a + b;
			sub:     result = a - b;
			and_op:  result = a & b;
			or_op:   result = a | b;
			shl:     result = a << shamt;
			shr:     result = a >> shamt; // Logical, zero fill
			mul:     result = product;
			default: result = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/gp_register.sv
`timescale 1ns/1ns
`default_nettype none

module gp_register #(
	parameter int idx = 0
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  cpu_pkg::ctrl_t             ctrl,
	input  logic [cpu_pkg::data_w-1:0] bus,
	output logic [cpu_pkg::data_w-1:0] q
);
	import cpu_pkg::*;

	logic [data_w-1:0] value;

	always_ff @(posedge clk) begin
		if (!rst_n)
			value <= '0;
		else if (ctrl.gpr_we && ctrl.gpr_write == reg_idx_t'(idx))
			value <= bus;
	end

	// Zero unless selected, so the slices can be ORed together
	assign q = (ctrl.gpr_read == reg_idx_t'(idx)) ? value : '0;

endmodule

`default_nettype wire

// File: rtl/bus_mux.sv
`timescale 1ns/1ns
`default_nettype none

module bus_mux (
	input  cpu_pkg::ctrl_t             ctrl,
	input  logic [cpu_pkg::data_w-1:0] gpr [cpu_pkg::num_regs],
	input  logic [cpu_pkg::data_w-1:0] pc,
	input  logic [cpu_pkg::data_w-1:0] mdr,
	input  logic [cpu_pkg::data_w-1:0] z,
	input  logic [cpu_pkg::data_w-1:0] imm,
	output logic [cpu_pkg::data_w-1:0] bus
);
	import cpu_pkg::*;

	logic [data_w-1:0] gpr_word;

	// Only the selected slice is nonzero
	always_comb begin
		gpr_word = '0;
		for (int i = 0; i < num_regs; i++)
			gpr_word = gpr_word | gpr[i];
	end

	always_comb begin
		case (ctrl.bus_src)
			src_gpr: bus = gpr_word;
			src_pc:  bus = pc;
			src_mdr: bus = mdr;
			src_z:   bus = z;
			src_imm: bus = imm;
			default: bus = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/datapath.sv
`timescale 1ns/1ns
`default_nettype none

module datapath (
	input  logic                        clk,
	input  logic                        rst_n,
	input  cpu_pkg::ctrl_t              ctrl,
	input  cpu_pkg::wb_rsp_t            wb_rsp,
	output logic [cpu_pkg::data_w-1:0]  mar,
	output cpu_pkg::instr_t             instr,
	output logic [cpu_pkg::data_w-1:0]  out_data,
	output logic                        out_valid
);
	import cpu_pkg::*;

	logic [data_w-1:0] bus;
	logic [data_w-1:0] pc;
	logic [data_w-1:0] mdr;
	logic [data_w-1:0] y;
	logic [data_w-1:0] z;
	logic [data_w-1:0] imm;
	logic [data_w-1:0] bus_inc;
	logic [data_w-1:0] alu_result;
	logic [data_w-1:0] gpr_q [num_regs];

	// Immediate is sign-extended from the itype view
	assign imm = {{(data_w - imm_w){instr.itype.imm[imm_w-1]}}, instr.itype.imm};

	assign bus_inc = bus + 1'b1; // PC increment adder, apart from the ALU

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc        <= '0;
			out_data  <= '0;
			out_valid <= 1'b0;
		end else begin
			if (ctrl.pc_we)
				pc <= bus;
			if (ctrl.out_we)
				out_data <= bus;
			out_valid <= ctrl.out_we; // One-cycle strobe with the new value
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.mar_we)
			mar <= bus;
		if (ctrl.mdr_we && wb_rsp.ack)
			mdr <= wb_rsp.dat;
		if (ctrl.ir_we)
			instr <= bus;
		if (ctrl.y_we)
			y <= bus;
		if (ctrl.z_we)
			z <= ctrl.pc_inc ? bus_inc : alu_result;
	end

	genvar i;
	generate
		for (i = 0; i < num_regs; i++) begin : g_gpr
			gp_register #(
				.idx(i)
			) u_gpr (
				.clk   (clk),
				.rst_n (rst_n),
				.ctrl  (ctrl),
				.bus   (bus),
				.q     (gpr_q[i])
			);
		end
	endgenerate

	bus_mux u_bus_mux (
		.ctrl (ctrl),
		.gpr  (gpr_q),
		.pc   (pc),
		.mdr  (mdr),
		.z    (z),
		.imm  (imm),
		.bus  (bus)
	);

	// Y is the first operand, the bus the second
	alu u_alu (
		.op     (ctrl.alu_op),
		.a      (y),
		.b      (bus),
		.result (alu_result)
	);

endmodule

`default_nettype wire

// File: rtl/cpu_control.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_control (
	input  logic             clk,
	input  logic             rst_n,
	input  cpu_pkg::instr_t  instr,
	input  cpu_pkg::wb_rsp_t wb_rsp,
	output cpu_pkg::wb_req_t wb_req,
	output cpu_pkg::ctrl_t   ctrl,
	output logic             halted
);
	import cpu_pkg::*;

	typedef enum logic [2:0] {
		st_t0   = 3'd0,
		st_t1   = 3'd1,
		st_t2   = 3'd2,
		st_t3   = 3'd3,
		st_t4   = 3'd4,
		st_t5   = 3'd5,
		st_halt = 3'd6
	} step_t;

	step_t step;
	step_t step_nx;
	logic  req_on; // Drives both cyc and stb

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			step   <= st_t0;
			req_on <= 1'b0;
		end else begin
			step <= step_nx;
			if (step == st_t0)
				req_on <= 1'b1; // Fetch starts with MAR loaded on this edge
			else if (step == st_t1 && wb_rsp.ack)
				req_on <= 1'b0;
		end
	end

	// The address is merged from MAR at the top level
	assign wb_req = '{cyc: req_on, stb: req_on, adr: '0};
	assign halted = (step == st_halt);

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = instr.rtype.opcode;
		step_nx     = step;

		case (step)
			st_t0: begin
				ctrl.bus_src = src_pc;
				ctrl.mar_we  = 1'b1;
				ctrl.pc_inc  = 1'b1;
				ctrl.z_we    = 1'b1;
				step_nx      = st_t1;
			end
			st_t1: begin
				// Held here through wait states
				ctrl.bus_src = src_z;
				ctrl.mdr_we  = 1'b1;
				ctrl.pc_we   = wb_rsp.ack;
				if (wb_rsp.ack)
					step_nx = st_t2;
			end
			st_t2: begin
				ctrl.bus_src = src_mdr;
				ctrl.ir_we   = 1'b1;
				step_nx      = st_t3;
			end
			st_t3: begin
				case (instr.rtype.opcode)
					add, sub, and_op, or_op, shl, shr, mul: begin
						ctrl.bus_src  = src_gpr;
						ctrl.gpr_read = instr.rtype.rb;
						ctrl.y_we     = 1'b1;
						step_nx       = st_t4;
					end
					ldi: begin
						ctrl.bus_src   = src_imm;
						ctrl.gpr_write = instr.itype.ra;
						ctrl.gpr_we    = 1'b1;
						step_nx        = st_t0;
					end
					out: begin
						ctrl.bus_src  = src_gpr;
						ctrl.gpr_read = instr.itype.rb;
						ctrl.out_we   = 1'b1;
						step_nx       = st_t0;
					end
					halt: step_nx = st_halt;
					default: step_nx = st_t0; // Unknown opcode runs as a no-op
				endcase
			end
			st_t4: begin
				ctrl.bus_src  = src_gpr;
				ctrl.gpr_read = instr.rtype.rc;
				ctrl.z_we     = 1'b1; // Z takes Y op rc
				step_nx       = st_t5;
			end
			st_t5: begin
				ctrl.bus_src   = src_z;
				ctrl.gpr_write = instr.rtype.ra;
				ctrl.gpr_we    = 1'b1;
				step_nx        = st_t0;
			end
			st_halt: step_nx = st_halt;
			default: step_nx = st_t0;
		endcase
	end

endmodule

`default_nettype wire

// File: rtl/cpu_top.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_top (
	input  logic                       clk,
	input  logic                       rst_n,
	output cpu_pkg::wb_req_t           wb_req,
	input  cpu_pkg::wb_rsp_t           wb_rsp,
	output logic [cpu_pkg::data_w-1:0] out_data,
	output logic                       out_valid,
	output logic                       halted
);
	import cpu_pkg::*;

	ctrl_t             ctrl;
	instr_t            instr;
	wb_req_t           ctl_req;
	logic [data_w-1:0] mar;

	// Handshake from the sequencer, address from MAR
	assign wb_req = '{cyc: ctl_req.cyc, stb: ctl_req.stb, adr: mar};

	cpu_control u_control (
		.clk    (clk),
		.rst_n  (rst_n),
		.instr  (instr),
		.wb_rsp (wb_rsp),
		.wb_req (ctl_req),
		.ctrl   (ctrl),
		.halted (halted)
	);

	datapath u_datapath (
		.clk       (clk),
		.rst_n     (rst_n),
		.ctrl      (ctrl),
		.wb_rsp    (wb_rsp),
		.mar       (mar),
		.instr     (instr),
		.out_data  (out_data),
		.out_valid (out_valid)
	);

endmodule

`default_nettype wire

// File: tests/cpu_checker.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_checker (
	input logic             clk,
	input logic             rst_n,
	input cpu_pkg::wb_req_t wb_req,
	input cpu_pkg::wb_rsp_t wb_rsp,
	input logic             out_valid,
	input logic             halted
);

	stb_needs_cyc: assert property (@(posedge clk) disable iff (!rst_n)
		wb_req.stb |-> wb_req.cyc)
		else $error("stb high without cyc");

	// Request holds through wait states
	req_held: assert property (@(posedge clk) disable iff (!rst_n)
		wb_req.stb && !wb_rsp.ack |=> wb_req.stb && $stable(wb_req.adr))
		else $error("Fetch request changed before ack");

	out_pulse: assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |=> !out_valid)
		else $error("out_valid longer than one cycle");

	halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> halted)
		else $error("halted fell without reset");

endmodule

bind cpu_top cpu_checker u_checker (
	.clk       (clk),
	.rst_n     (rst_n),
	.wb_req    (wb_req),
	.wb_rsp    (wb_rsp),
	.out_valid (out_valid),
	.halted    (halted)
);

`default_nettype wire

// File: tests/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_tb;
	import cpu_pkg::*;

	typedef struct packed {
		logic [31:0] word;
		logic        has_out;
		logic [31:0] expect_val;
	} row_t;

	logic              clk = 1'b0;
	logic              rst_n;
	wb_req_t           wb_req;
	wb_rsp_t           wb_rsp;
	logic [data_w-1:0] out_data;
	logic              out_valid;
	logic              halted;

	row_t        prog [$]; // Program table
	logic [31:0] exp_q [$]; // Outputs still to be seen in program order
	logic [31:0] mem [0:63];
	integer      seed = 95;
	int          wait_left;
	logic        busy; // Current fetch already has its wait states chosen
	int          fetch_count;
	logic        halted_seen;
	logic        table_ready;

	cpu_top DUT (
		.clk       (clk),
		.rst_n     (rst_n),
		.wb_req    (wb_req),
		.wb_rsp    (wb_rsp),
		.out_data  (out_data),
		.out_valid (out_valid),
		.halted    (halted)
	);

	always #10 clk = ~clk;

	function automatic logic [31:0] sign_extend(input logic [18:0] v);
		return {{13{v[18]}}, v};
	endfunction

	function automatic logic [31:0] reg_op_word(input opcode_t op, input int ra, input int rb,
			input int rc);
		return {op, 4'(ra), 4'(rb), 4'(rc), 15'd0};
	endfunction

	function automatic logic [31:0] imm_op_word(input opcode_t op, input int ra, input int rb,
			input logic [18:0] imm);
		return {op, 4'(ra), 4'(rb), imm};
	endfunction

	task automatic stop_with_failure(input string line);
		$display("%s", line);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic push_row(input logic [31:0] word, input logic has_out, input logic [31:0] value);
		prog.push_back('{word, has_out, value});
	endtask

	task automatic build_program;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] s;
		logic [31:0] m1;
		a  = sign_extend(19'h12345);
		b  = sign_extend(19'h40f10); // Negative
		s  = sign_extend(19'd35);    // Low five bits give 3
		m1 = sign_extend(19'h7ffff);
		push_row(imm_op_word(ldi, 1, 0, 19'h12345), 1'b0, '0);
		push_row(imm_op_word(out, 0, 1, 19'd0), 1'b1, a);
		push_row(imm_op_word(ldi, 2, 0, 19'h40f10), 1'b0, '0);
		push_row(imm_op_word(out, 0, 2, 19'd0), 1'b1, b);
		push_row(reg_op_word(add, 3, 1, 2), 1'b0, '0);
		push_row(imm_op_word(out, 0, 3, 19'd0), 1'b1, a + b);
		push_row(reg_op_word(sub, 4, 1, 2), 1'b0, '0);
		push_row(imm_op_word(out, 0, 4, 19'd0), 1'b1, a - b);
		push_row(reg_op_word(sub, 5, 2, 1), 1'b0, '0);
		push_row(imm_op_word(out, 0, 5, 19'd0), 1'b1, b - a);
		push_row(reg_op_word(and_op, 6, 1, 2), 1'b0, '0);
		push_row(imm_op_word(out, 0, 6, 19'd0), 1'b1, a & b);
		push_row(reg_op_word(or_op, 7, 1, 2), 1'b0, '0);
		push_row(imm_op_word(out, 0, 7, 19'd0), 1'b1, a | b);
		push_row(imm_op_word(ldi, 8, 0, 19'd35), 1'b0, '0);
		push_row(reg_op_word(shl, 9, 1, 8), 1'b0, '0);
		push_row(imm_op_word(out, 0, 9, 19'd0), 1'b1, a << s[4:0]);
		push_row(reg_op_word(shr, 10, 2, 8), 1'b0, '0);
		push_row(imm_op_word(out, 0, 10, 19'd0), 1'b1, b >> s[4:0]);
		push_row(reg_op_word(mul, 11, 2, 2), 1'b0, '0);
		push_row(imm_op_word(out, 0, 11, 19'd0), 1'b1, b * b);
		push_row(reg_op_word(mul, 12, 1, 2), 1'b0, '0);
		push_row(imm_op_word(out, 0, 12, 19'd0), 1'b1, a * b);
		push_row(imm_op_word(ldi, 0, 0, 19'h7ffff), 1'b0, '0); // Register 0 is ordinary
		push_row(imm_op_word(out, 0, 0, 19'd0), 1'b1, m1);
		push_row(reg_op_word(add, 15, 0, 0), 1'b0, '0);
		push_row(imm_op_word(out, 0, 15, 19'd0), 1'b1, m1 + m1);
		push_row(imm_op_word(halt, 0, 0, 19'd0), 1'b0, '0);
	endtask

	// Memory model with random wait states
	always @(negedge clk) begin
		if (!rst_n) begin
			wb_rsp = '0;
			busy   = 1'b0;
		end else if (wb_rsp.ack) begin
			wb_rsp.ack = 1'b0; // cyc has dropped on the edge that took the ack
		end else if (wb_req.cyc && wb_req.stb) begin
			if (!busy) begin
				busy      = 1'b1;
				wait_left = $unsigned($random(seed)) % 4;
			end
			if (wait_left == 0) begin
				assert (fetch_count < prog.size())
					else stop_with_failure("Fetch request after the halt instruction");
				assert (wb_req.adr == 32'(fetch_count))
					else stop_with_failure($sformatf("error at %0t ns: fetch address %0d, expected %0d",
						$time, wb_req.adr, fetch_count));
				fetch_count++;
				wb_rsp.dat = mem[wb_req.adr[5:0]];
				wb_rsp.ack = 1'b1;
				busy       = 1'b0;
			end else begin
				wait_left--;
			end
		end
	end

	always @(negedge clk) begin : monitor
		logic [31:0] expected;
		if (!rst_n) begin
			assert (!wb_req.cyc && !out_valid && !halted)
				else stop_with_failure("Bus request, output strobe or halt active during reset");
		end else begin
			if (out_valid) begin
				assert (exp_q.size() > 0)
					else stop_with_failure("Output strobe with no output left in the program");
				expected = exp_q.pop_front();
				assert (out_data == expected)
					else stop_with_failure($sformatf("error at %0t ns: out_data %h, expected %h",
						$time, out_data, expected));
			end
			if (halted_seen) begin
				assert (halted && !wb_req.cyc && !out_valid)
					else stop_with_failure("Core left the halted state or kept working after halt");
			end
			if (halted && !halted_seen)
				halted_seen = 1'b1;
		end
	end

	initial begin : watchdog
		int limit;
		wait (table_ready);
		// Six steps plus three wait states per instruction and doubled
		limit = 2 * (prog.size() * (6 + 3) + 3 + 10);
		repeat (limit) @(posedge clk);
		stop_with_failure($sformatf("Timeout: the core did not halt within %0d cycles", limit));
	end

	initial begin
		rst_n       = 1'b0;
		wb_rsp      = '0;
		fetch_count = 0;
		halted_seen = 1'b0;
		busy        = 1'b0;
		wait_left   = 0;
		table_ready = 1'b0;
		build_program();
		for (int i = 0; i < 64; i++)
			mem[i] = {halt, 27'(i)}; // Beyond the program every word is a halt
		foreach (prog[i]) begin
			mem[i] = prog[i].word;
			if (prog[i].has_out)
				exp_q.push_back(prog[i].expect_val);
		end
		table_ready = 1'b1;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		wait (halted_seen);
		repeat (10) @(negedge clk); // Stays quiet after halt
		if (exp_q.size() == 0 && fetch_count == prog.size()) begin
			$display("Simulation completed successfully");
			$finish;
		end else begin
			stop_with_failure("Core halted before the whole program ran");
		end
	end

endmodule

`default_nettype wire

// File: list.f
rtl/cpu_pkg.sv
rtl/alu.sv
rtl/gp_register.sv
rtl/bus_mux.sv
rtl/datapath.sv
rtl/cpu_control.sv
rtl/cpu_top.sv
tests/cpu_checker.sv
tests/cpu_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build cpu_tb with Verilator, run it and check sim.log"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module cpu_tb -f list.f
	-./obj_dir/Vcpu_tb > sim.log 2>&1
	@cat sim.log
	@if grep -q "Simulation completed successfully" sim.log; then \
		echo "PASS"; \
	else \
		echo "FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
